// File: all.f
hw/md_pkg.sv
hw/mac_ctrl_if.sv
hw/mul_sequencer.sv
hw/mul_mac_unit.sv
hw/fast_mul.sv
verification/tb_clock_gen.sv
verification/fast_mul_props.sv
verification/fast_mul_tb.sv

// File: verification/mul_stimulus.txt
# op (0 MULL, 1 MULH)  mode (bit0 A signed, bit1 B signed)  A  B  ready_delay  expected
# all columns hex except ready_delay, which is decimal cycles
0 0 00000003 00000005 0 0000000f
0 0 00000000 12345678 0 00000000
0 3 ffffffff ffffffff 0 00000001
0 0 ffffffff 00000002 1 fffffffe
0 1 12345678 00000010 0 23456780
0 3 00010000 00010000 2 00000000
0 0 0000ffff 0000ffff 0 fffe0001
0 3 80000000 80000000 0 00000000
0 0 12345678 00000100 3 34567800
0 0 00012345 00001000 0 12345000
0 3 fffffffe 00000003 1 fffffffa
0 0 deadbeef 00000001 0 deadbeef
0 3 7fffffff 7fffffff 0 00000001
0 0 deadbeef 00010000 0 beef0000
1 0 ffffffff ffffffff 0 fffffffe
1 0 80000000 80000000 0 40000000
1 0 00010000 00010000 1 00000001
1 0 0000ffff 0000ffff 0 00000000
1 0 ffffffff 00000002 0 00000001
1 0 12345678 00000000 0 00000000
1 0 deadbeef 00010000 2 0000dead
1 3 ffffffff ffffffff 0 00000000
1 3 80000000 80000000 2 40000000
1 3 ffffffff 00000001 0 ffffffff
1 3 80000000 7fffffff 0 c0000000
1 3 7fffffff 7fffffff 0 3fffffff
1 3 fffffffe 00000003 3 ffffffff
1 3 00010000 fffe0000 0 fffffffe
1 3 deadbeef 00010000 0 ffffdead
1 1 ffffffff ffffffff 0 ffffffff
1 1 80000000 80000000 0 c0000000
1 1 00000002 ffffffff 0 00000001
1 1 fffffffe 00000003 1 ffffffff
1 1 7fffffff ffffffff 0 7ffffffe
1 1 ffff0000 00010000 0 ffffffff
0 1 ffff0000 00010000 2 00000000

// File: verification/fast_mul_tb.sv
`timescale 1ns/1ps
// Testbench for the iterative 32-bit multiplier
// Runs file vectors and seeded random vectors with back-pressure and checks
// result, latency and valid behavior

module fast_mul_tb;

  import md_pkg::*;

  localparam int ValidTimeout = 20;
  localparam int ResetTimeout = 40;
  localparam int NumRandom    = 20;

  logic        clk;
  logic        rst_n;
  logic        mult_en;
  md_op_e      operator;
  logic [1:0]  signed_mode;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        ready;
  logic [31:0] result;
  logic        valid;

  int          errors;
  int          checks;
  bit          aborted;
  integer      seed;

  tb_clock_gen u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  fast_mul dut0 (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .mult_en_i     (mult_en),
    .operator_i    (operator),
    .signed_mode_i (signed_mode),
    .op_a_i        (op_a),
    .op_b_i        (op_b),
    .ready_i       (ready),
    .result_o      (result),
    .valid_o       (valid)
  );

  // Low or high word of the full product with each operand extended by its mode bit
  function automatic logic [31:0] expected_product(input logic op, input logic [1:0] mode,
                                                   input logic [31:0] a,
                                                   input logic [31:0] b);
    logic signed [64:0] ext_a;
    logic signed [64:0] ext_b;
    logic signed [64:0] prod;
    ext_a = {{33{mode[0] & a[31]}}, a};
    ext_b = {{33{mode[1] & b[31]}}, b};
    prod  = ext_a * ext_b;
    if (op) begin
      return prod[63:32];
    end else begin
      return prod[31:0];
    end
  endfunction

  // One cycle with the enable low and valid expected low
  task automatic idle_cycle();
    mult_en = 1'b0;
    ready   = 1'b1;
    @(negedge clk);
    if (valid !== 1'b0) begin
      $display("** Error valid_o with mult_en_i low: expected 0, got %h", valid);
      errors++;
    end
    @(posedge clk);
    #2;
  endtask

  // Starts at 2 ns after a rising edge and returns at the same point after the handshake
  task automatic run_op(input logic op, input logic [1:0] mode, input logic [31:0] a,
                        input logic [31:0] b, input int delay,
                        input logic [31:0] expected);
    int          cycle;
    int          want_cycle;
    int          i;
    logic [31:0] held;
    mult_en     = 1'b1;
    operator    = md_op_e'(op);
    signed_mode = mode;
    op_a        = a;
    op_b        = b;
    ready       = (delay == 0);
    want_cycle  = op ? 4 : 3;
    cycle       = 0;
    do begin
      @(negedge clk);
      cycle++;
    end while (valid !== 1'b1 && cycle < ValidTimeout);

    if (valid !== 1'b1) begin
      $display("Timeout: valid_o did not rise within %0d cycles (A %h, B %h)",
               ValidTimeout, a, b);
      errors++;
      aborted = 1'b1;
    end else begin
      checks++;
      if (cycle != want_cycle) begin
        $display("valid_o rose in cycle %0d instead of cycle %0d", cycle, want_cycle);
        errors++;
      end
      held = result;
      // Result must not move while the consumer stalls
      for (i = 0; i < delay; i++) begin
        @(posedge clk);
        #2;
        if (i == delay - 1) begin
          ready = 1'b1;
        end
        @(negedge clk);
        if (valid !== 1'b1) begin
          $display("** Error valid_o under back-pressure: expected 1, got %h", valid);
          errors++;
        end
        if (result !== held) begin
          $display("** Error result_o under back-pressure: expected %h, got %h",
                   held, result);
          errors++;
        end
      end
      if (result !== expected) begin
        $display("** Error result_o: expected %h, got %h (op %0d, mode %0h, A %h, B %h)",
                 expected, result, op, mode, a, b);
        errors++;
      end
      @(posedge clk);
      #2;
    end
  endtask

  initial begin
    int          fd;
    int          count;
    int          n;
    int          vec_idx;
    int          k;
    string       line;
    logic [3:0]  f_op;
    logic [3:0]  f_mode;
    logic [31:0] f_a;
    logic [31:0] f_b;
    int          f_delay;
    logic [31:0] f_exp;
    logic [31:0] r_a;
    logic [31:0] r_b;
    logic [31:0] r_ctl;
    logic        r_op;
    logic [1:0]  r_mode;
    int          r_delay;

    errors      = 0;
    checks      = 0;
    aborted     = 1'b0;
    seed        = 32'h50a8;
    mult_en     = 1'b0;
    operator    = MD_OP_MULL;
    signed_mode = 2'b00;
    op_a        = '0;
    op_b        = '0;
    ready       = 1'b1;

    // valid_o must stay low while reset is applied
    count = 0;
    while (rst_n !== 1'b1 && count < ResetTimeout) begin
      @(negedge clk);
      count++;
      if (valid !== 1'b0) begin
        $display("** Error valid_o during reset: expected 0, got %h", valid);
        errors++;
      end
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was not released within %0d cycles", ResetTimeout);
      errors++;
      aborted = 1'b1;
    end
    @(posedge clk);
    #2;

    fd = $fopen("verification/mul_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verification/mul_stimulus.txt");
      errors++;
    end else begin
      vec_idx = 0;
      while (!$feof(fd) && !aborted) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %d %h", f_op, f_mode, f_a, f_b, f_delay, f_exp);
          if (n != 6) begin
            $display("Malformed stimulus line: %s", line);
            errors++;
          end else begin
            run_op(f_op[0], f_mode[1:0], f_a, f_b, f_delay, f_exp);
            // Every third vector gets an idle cycle and the others run back to back
            if (!aborted && (vec_idx % 3 == 2)) begin
              idle_cycle();
            end
            vec_idx++;
          end
        end
      end
      $fclose(fd);
    end

    for (k = 0; k < NumRandom && !aborted; k++) begin
      r_a     = $random(seed);
      r_b     = $random(seed);
      r_ctl   = $random(seed);
      r_op    = r_ctl[0];
      r_mode  = (r_ctl[2:1] == 2'd0) ? 2'b00 : (r_ctl[2:1] == 2'd1) ? 2'b01 : 2'b11;
      r_delay = r_ctl[5:4];
      run_op(r_op, r_mode, r_a, r_b, r_delay, expected_product(r_op, r_mode, r_a, r_b));
      if (!aborted && r_ctl[6]) begin
        idle_cycle();
      end
    end

    mult_en = 1'b0;
    $display("Results checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/fast_mul_props.sv
`timescale 1ns/1ps
// Handshake and state checks for the multiplier sequencer
// Attached to every mul_sequencer instance

module fast_mul_props (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               mult_en_i,
  input logic               ready_i,
  input logic               valid_i,
  input md_pkg::mul_state_e state_i
);

  // A held result keeps valid up and freezes the sequencer
  hold_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      (valid_i && !ready_i) |=> (valid_i && $stable(state_i)))
    else $error("valid_o dropped or state moved while the result was held");

  state_known_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      !$isunknown(state_i))
    else $error("sequencer state is unknown");

  // A result needs the request held through the whole operation
  valid_needs_en_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> (mult_en_i && $past(mult_en_i) && $past(mult_en_i, 2)))
    else $error("valid_o high without mult_en_i held since the operation started");

endmodule

bind mul_sequencer fast_mul_props u_props (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .mult_en_i (mult_en_i),
  .ready_i   (ready_i),
  .valid_i   (valid_o),
  .state_i   (state_q)
);

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
// Testbench clock and reset source
// 20 ns clock, reset held low for the first 10 cycles

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 10;
  localparam int ResetCycles = 10;

  initial begin
    clk_o = 1'b0;
    forever begin
      #HalfPeriod clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release away from the rising edge
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: hw/fast_mul.sv
`timescale 1ns/1ps
// Iterative 32-bit integer multiplier
// MULL in three cycles and MULH in four on one shared 17x17 MAC

module fast_mul (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         mult_en_i,
  input  md_pkg::md_op_e               operator_i,
  input  logic [1:0]                   signed_mode_i,
  input  logic [md_pkg::DataWidth-1:0] op_a_i,
  input  logic [md_pkg::DataWidth-1:0] op_b_i,
  input  logic                         ready_i,
  output logic [md_pkg::DataWidth-1:0] result_o,
  output logic                         valid_o
);

  import md_pkg::*;

  // Sequencer to MAC control
  mac_ctrl_if ctrl_if ();

  // Operand sign bits feed the per-state sign selection
  mul_sequencer u_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mult_en_i     (mult_en_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_msb_i    (op_a_i[DataWidth-1]),
    .op_b_msb_i    (op_b_i[DataWidth-1]),
    .ready_i       (ready_i),
    .ctrl          (ctrl_if.seq),
    .valid_o       (valid_o)
  );

  mul_mac_unit u_mac (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .signed_mode_i (signed_mode_i),
    .ctrl          (ctrl_if.mac),
    .result_o      (result_o)
  );

endmodule

// File: hw/mul_mac_unit.sv
`timescale 1ns/1ps
// Multiply-accumulate datapath of the iterative multiplier
// One 17x17 signed product per cycle plus an addend taken from the accumulator,
// with low-word packing for MULL

module mul_mac_unit (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [md_pkg::DataWidth-1:0] op_a_i,
  input  logic [md_pkg::DataWidth-1:0] op_b_i,
  input  logic [1:0]                   signed_mode_i,
  mac_ctrl_if.mac                      ctrl,
  output logic [md_pkg::DataWidth-1:0] result_o
);

  import md_pkg::*;

  logic [HalfWidth-1:0]     mult_op_a;
  logic [HalfWidth-1:0]     mult_op_b;
  logic                     a_high;
  logic                     b_high;
  logic                     signed_mult;
  logic [AccWidth-1:0]      acc_q;
  logic [AccWidth-1:0]      acc_d;
  logic [AccWidth-1:0]      acc_shr;
  logic [AccWidth-1:0]      acc_shr_ext;
  logic [AccWidth-1:0]      low_packed;
  logic [AccWidth-1:0]      addend;
  logic signed [AccWidth:0] mac_sum;
  logic [AccWidth-1:0]      mac_res;

  // Half-word selection
  assign a_high = (ctrl.state == AHBL) || (ctrl.state == AHBH);
  assign b_high = (ctrl.state == ALBH) || (ctrl.state == AHBH);

  assign mult_op_a = a_high ? op_a_i[HalfWidth +: HalfWidth] : op_a_i[0 +: HalfWidth];
  assign mult_op_b = b_high ? op_b_i[HalfWidth +: HalfWidth] : op_b_i[0 +: HalfWidth];

  assign signed_mult = (signed_mode_i != 2'b00);

  // Upper 16 bits of the stored low word, always a positive carry-in
  assign acc_shr = {{(AccWidth - HalfWidth){1'b0}}, acc_q[DataWidth-1:HalfWidth]};

  // Accumulator shifted down by a half-word, extended for the final product
  assign acc_shr_ext = {{HalfWidth{signed_mult & acc_q[AccWidth-1]}},
                        acc_q[AccWidth-1:HalfWidth]};

  // The two top bits of the sum always agree, so bit AccWidth is dropped
  assign mac_sum = $signed({ctrl.sign_a, mult_op_a}) * $signed({ctrl.sign_b, mult_op_b}) +
                   $signed(addend);
  assign mac_res = mac_sum[AccWidth-1:0];

  // New low half-word above the stored one
  assign low_packed = {{(AccWidth - DataWidth){1'b0}}, mac_res[HalfWidth-1:0],
                       acc_q[HalfWidth-1:0]};

  always_comb begin
    addend = '0;
    acc_d  = mac_res;
    case (ctrl.state)
      ALBL: begin
        addend = '0;
      end
      ALBH: begin
        addend = acc_shr;
        if (ctrl.op == MD_OP_MULL) begin
          acc_d = low_packed;
        end
      end
      AHBL: begin
        // MULH keeps the full sum, both cross products share a weight
        if (ctrl.op == MD_OP_MULL) begin
          addend = acc_shr;
          acc_d  = low_packed;
        end else begin
          addend = acc_q;
        end
      end
      AHBH: begin
        addend = acc_shr_ext;
      end
      default: begin
        addend = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (ctrl.step_en) begin
      acc_q <= acc_d;
    end
  end

  // Result is the value about to be captured
  assign result_o = acc_d[DataWidth-1:0];

endmodule

// File: hw/mul_sequencer.sv
`timescale 1ns/1ps
// Multiplier sequencer
// Steps through the four partial products, raises valid on the last one
// and freezes while the consumer is not ready

module mul_sequencer (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           mult_en_i,
  input  md_pkg::md_op_e operator_i,
  input  logic [1:0]     signed_mode_i,
  input  logic           op_a_msb_i,
  input  logic           op_b_msb_i,
  input  logic           ready_i,
  mac_ctrl_if.seq        ctrl,
  output logic           valid_o
);

  import md_pkg::*;

  mul_state_e state_q;
  mul_state_e state_d;
  logic       last_state;
  logic       hold;
  logic       step_en;
  logic       a_high;
  logic       b_high;
  logic       sign_a_op;
  logic       sign_b_op;

  // MULL finishes after three partial products, MULH after four
  assign last_state = (state_q == AHBH) ||
                      ((state_q == AHBL) && (operator_i == MD_OP_MULL));

  assign valid_o = mult_en_i & last_state;

  // Result waits for the consumer
  assign hold = valid_o & ~ready_i;

  assign step_en = mult_en_i & ~hold;

  // Next partial product
  always_comb begin
    state_d = state_q;
    case (state_q)
      ALBL: begin
        state_d = ALBH;
      end
      ALBH: begin
        state_d = AHBL;
      end
      AHBL: begin
        if (operator_i == MD_OP_MULL) begin
          state_d = ALBL;
        end else begin
          state_d = AHBH;
        end
      end
      AHBH: begin
        state_d = ALBL;
      end
      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // State moves only on enabled cycles that are not held
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (step_en) begin
      state_q <= state_d;
    end
  end

  // Which operand halves are in use this cycle
  assign a_high = (state_q == AHBL) || (state_q == AHBH);
  assign b_high = (state_q == ALBH) || (state_q == AHBH);

  // Operand signs as requested by the instruction
  assign sign_a_op = signed_mode_i[0] & op_a_msb_i;
  assign sign_b_op = signed_mode_i[1] & op_b_msb_i;

  // Low halves are always unsigned, so a sign only applies to an upper half
  assign ctrl.sign_a  = a_high & sign_a_op;
  assign ctrl.sign_b  = b_high & sign_b_op;

  assign ctrl.state   = state_q;
  assign ctrl.step_en = step_en;
  assign ctrl.op      = operator_i;

endmodule

// File: hw/mac_ctrl_if.sv
`timescale 1ns/1ps
// MAC control bundle between the multiplier sequencer and the MAC unit
// Carries the current partial product, the capture strobe and the operand signs

interface mac_ctrl_if;

  import md_pkg::*;

  // Partial product worked on this cycle
  mul_state_e state;

  // Accumulator capture strobe, low while the result is held
  logic       step_en;

  // Requested product word
  md_op_e     op;

  // Effective signs of the half-words in use
  logic       sign_a;
  logic       sign_b;

  modport seq (
    output state,
    output step_en,
    output op,
    output sign_a,
    output sign_b
  );

  modport mac (
    input state,
    input step_en,
    input op,
    input sign_a,
    input sign_b
  );

endinterface

// File: hw/md_pkg.sv
// Shared definitions for the iterative 32-bit multiplier
// Operation and sequencer state encodings plus the datapath widths
package md_pkg;

  // Operand and result width
  localparam int unsigned DataWidth = 32;

  // Half-word fed to the 17x17 signed multiplier
  localparam int unsigned HalfWidth = DataWidth / 2;

  // Partial sum with two guard bits on top
  localparam int unsigned AccWidth = DataWidth + 2;

  // Requested product word
  typedef enum logic {
    MD_OP_MULL,
    MD_OP_MULH
  } md_op_e;

  // One state per partial product, named after the half-words in use
  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mul_state_e;

endpackage
